//--- src/datapath_defs.svh
`ifndef DATAPATH_DEFS_SVH
`define DATAPATH_DEFS_SVH

// one machine word
`define DATA_W 32

// general register file size, r0 included
`define REG_COUNT 32

// data memory in words, indexed by result bits 7 down to 2
`define MEM_DEPTH 64

// jump-and-link writes pc plus 8 into r31
`define LINK_REG 31
`define LINK_OFFSET 8

`endif

//--- src/datapathPkg.sv
`default_nettype none

`include "datapath_defs.svh"

package datapathPkg;

	typedef logic [`DATA_W-1:0] wordT;
	typedef logic [$clog2(`REG_COUNT)-1:0] regAddrT;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT // signed compare
	} aluOpT;

	typedef enum logic [1:0] {DST_RT, DST_RD, DST_LINK} dstSelT;
	typedef enum logic [1:0] {RES_ALU, RES_IMM, RES_LINK} resSelT;

	// decoded instruction as handed over by the decoder
	typedef struct packed {
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
		wordT    imm; // already extended
		wordT    pc;
		aluOpT   aluOp;
		logic    useImm;
		dstSelT  dstSel;
		resSelT  resSel;
		logic    memRead;
		logic    memWrite;
		logic    regWrite;
	} instrT;

	typedef struct packed {
		logic    valid;
		regAddrT dst;
		wordT    result;
		wordT    storeData;
		logic    memRead;
		logic    memWrite;
		logic    regWrite;
	} memStageT;

	typedef struct packed {
		logic    valid;
		regAddrT dst;
		wordT    result;
		wordT    loadData;
		logic    memRead;
		logic    regWrite;
	} wbStageT;

	// valid here already means the stage will write dst
	typedef struct packed {
		logic    valid;
		regAddrT dst;
		wordT    value;
	} fwdT;

endpackage

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defs.svh"

module regFile (
	input  logic                clk,
	input  logic                rst,
	input  datapathPkg::regAddrT raddrA,
	input  datapathPkg::regAddrT raddrB,
	output datapathPkg::wordT    rdataA,
	output datapathPkg::wordT    rdataB,
	input  logic                we,
	input  datapathPkg::regAddrT waddr,
	input  datapathPkg::wordT    wdata
);
	import datapathPkg::*;

	wordT regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin // r0 is hardwired
			regs[waddr] <= wdata;
		end
	end

	// no internal bypass, the writeback stage forwards a same-cycle write
	assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
	assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

	// r0 must stay zero across every writeback, including writes that target it
	r0StaysZero: assert property (@(posedge clk) disable iff (rst)
		regs[0] == '0)
		else $error("regFile: r0 holds a nonzero value");

endmodule

`default_nettype wire

//--- src/bypassUnit.sv
`timescale 1ns/1ps
`default_nettype none

module bypassUnit (
	input  datapathPkg::regAddrT rsAddr,
	input  datapathPkg::regAddrT rtAddr,
	input  datapathPkg::wordT    rsFile,
	input  datapathPkg::wordT    rtFile,
	input  datapathPkg::fwdT     memFwd,
	input  datapathPkg::fwdT     wbFwd,
	output datapathPkg::wordT    rsVal,
	output datapathPkg::wordT    rtVal
);
	import datapathPkg::*;

	typedef enum logic [1:0] {SRC_FILE, SRC_MEM, SRC_WB} srcT;

	srcT rsSrc;
	srcT rtSrc;

	// the younger result in the memory stage shadows the one in writeback
	function automatic srcT pickSrc(input regAddrT addr, input fwdT memF, input fwdT wbF);
		srcT src;
		src = SRC_FILE;
		if (addr != '0) begin
			if (memF.valid && memF.dst == addr) begin
				src = SRC_MEM;
			end else if (wbF.valid && wbF.dst == addr) begin
				src = SRC_WB;
			end
		end
		return src;
	endfunction

	function automatic wordT muxSrc(input srcT src, input wordT fileVal,
			input fwdT memF, input fwdT wbF);
		wordT val;
		case (src)
			SRC_MEM: val = memF.value;
			SRC_WB:  val = wbF.value;
			default: val = fileVal;
		endcase
		return val;
	endfunction

	assign rsSrc = pickSrc(rsAddr, memFwd, wbFwd);
	assign rtSrc = pickSrc(rtAddr, memFwd, wbFwd);

	assign rsVal = muxSrc(rsSrc, rsFile, memFwd, wbFwd);
	assign rtVal = muxSrc(rtSrc, rtFile, memFwd, wbFwd);

endmodule

`default_nettype wire

//--- src/execStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defs.svh"

module execStage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 issueValid,
	input  datapathPkg::instrT    issue,
	input  datapathPkg::wordT     rsVal,
	input  datapathPkg::wordT     rtVal,
	output datapathPkg::memStageT memReg
);
	import datapathPkg::*;

	wordT    opB;
	wordT    aluOut;
	wordT    result;
	regAddrT dst;

	assign opB = issue.useImm ? issue.imm : rtVal;

	always_comb begin
		case (issue.aluOp)
			ALU_ADD: aluOut = rsVal + opB;
			ALU_SUB: aluOut = rsVal - opB;
			ALU_AND: aluOut = rsVal & opB;
			ALU_OR:  aluOut = rsVal | opB;
			ALU_XOR: aluOut = rsVal ^ opB;
			ALU_SLT: aluOut = wordT'($signed(rsVal) < $signed(opB));
			default: aluOut = '0;
		endcase
	end

	// the link value skips the delay slot
	always_comb begin
		case (issue.resSel)
			RES_ALU: result = aluOut;
			RES_IMM: result = issue.imm;
			default: result = issue.pc + wordT'(`LINK_OFFSET);
		endcase
	end

	always_comb begin
		case (issue.dstSel)
			DST_RT:  dst = issue.rt;
			DST_RD:  dst = issue.rd;
			default: dst = regAddrT'(`LINK_REG);
		endcase
	end

	always_ff @(posedge clk) begin
		memReg.dst       <= dst;
		memReg.result    <= result;
		memReg.storeData <= rtVal; // forwarded rt, so a store sees the newest value
		memReg.memRead   <= issue.memRead;
		memReg.memWrite  <= issue.memWrite;
		memReg.regWrite  <= issue.regWrite;
		if (rst) begin
			memReg.valid <= 1'b0;
		end else begin
			memReg.valid <= issueValid;
		end
	end

	// the decoder must never hand over the spare select codes
	selEncodingValid: assert property (@(posedge clk) disable iff (rst)
		issueValid |-> (issue.dstSel inside {DST_RT, DST_RD, DST_LINK}) &&
			(issue.resSel inside {RES_ALU, RES_IMM, RES_LINK}))
		else $error("execStage: undefined dstSel or resSel on issue");

endmodule

`default_nettype wire

//--- src/memStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defs.svh"

module memStage (
	input  logic                 clk,
	input  logic                 rst,
	input  datapathPkg::memStageT memReg,
	output datapathPkg::fwdT      memFwd,
	output datapathPkg::wbStageT  wbReg
);
	import datapathPkg::*;

	localparam int IdxW = $clog2(`MEM_DEPTH);

	wordT            mem [`MEM_DEPTH];
	logic [IdxW-1:0] wordIdx;
	wordT            loadData;

	assign wordIdx  = memReg.result[IdxW+1:2]; // word addressed, low two bits ignored
	assign loadData = mem[wordIdx];

	always_ff @(posedge clk) begin
		if (memReg.valid && memReg.memWrite) begin
			mem[wordIdx] <= memReg.storeData;
		end
	end

	// a load forwards its memory data so the next instruction needs no stall
	assign memFwd.valid = memReg.valid && memReg.regWrite;
	assign memFwd.dst   = memReg.dst;
	assign memFwd.value = memReg.memRead ? loadData : memReg.result;

	always_ff @(posedge clk) begin
		wbReg.dst      <= memReg.dst;
		wbReg.result   <= memReg.result;
		wbReg.loadData <= loadData;
		wbReg.memRead  <= memReg.memRead;
		wbReg.regWrite <= memReg.regWrite;
		if (rst) begin
			wbReg.valid <= 1'b0;
		end else begin
			wbReg.valid <= memReg.valid;
		end
	end

	// a single access per instruction, the decoder never sets both
	noLoadAndStore: assert property (@(posedge clk) disable iff (rst)
		memReg.valid |-> !(memReg.memRead && memReg.memWrite))
		else $error("memStage: load and store set on the same entry");

endmodule

`default_nettype wire

//--- src/writebackStage.sv
`timescale 1ns/1ps
`default_nettype none

module writebackStage (
	input  datapathPkg::wbStageT wbReg,
	output datapathPkg::fwdT     wbFwd,
	output logic                regWe,
	output datapathPkg::regAddrT regWaddr,
	output datapathPkg::wordT    regWdata,
	output logic                wbValid,
	output datapathPkg::regAddrT wbDst,
	output datapathPkg::wordT    wbData
);
	import datapathPkg::*;

	wordT wbValue;

	assign wbValue = wbReg.memRead ? wbReg.loadData : wbReg.result;

	// stores reach this stage too but never write a register
	assign regWe    = wbReg.valid && wbReg.regWrite;
	assign regWaddr = wbReg.dst;
	assign regWdata = wbValue;

	assign wbValid = regWe; // also reported for r0, the file drops that write
	assign wbDst   = wbReg.dst;
	assign wbData  = wbValue;

	// covers the cycle in which the file is being written
	assign wbFwd.valid = regWe;
	assign wbFwd.dst   = wbReg.dst;
	assign wbFwd.value = wbValue;

endmodule

`default_nettype wire

//--- src/execPipe.sv
`timescale 1ns/1ps
`default_nettype none

module execPipe (
	input  logic                clk,
	input  logic                rst,
	input  logic                issueValid,
	input  datapathPkg::instrT   issue,
	output logic                wbValid,
	output datapathPkg::regAddrT wbDst,
	output datapathPkg::wordT    wbData
);
	import datapathPkg::*;

	wordT     rsFile;
	wordT     rtFile;
	wordT     rsVal;
	wordT     rtVal;
	fwdT      memFwd;
	fwdT      wbFwd;
	memStageT memReg;
	wbStageT  wbReg;
	logic     regWe;
	regAddrT  regWaddr;
	wordT     regWdata;

	regFile uRegFile (
		.clk    (clk),
		.rst    (rst),
		.raddrA (issue.rs),
		.raddrB (issue.rt),
		.rdataA (rsFile),
		.rdataB (rtFile),
		.we     (regWe),
		.waddr  (regWaddr),
		.wdata  (regWdata)
	);

	bypassUnit uBypass (
		.rsAddr (issue.rs),
		.rtAddr (issue.rt),
		.rsFile (rsFile),
		.rtFile (rtFile),
		.memFwd (memFwd),
		.wbFwd  (wbFwd),
		.rsVal  (rsVal),
		.rtVal  (rtVal)
	);

	execStage uExec (
		.clk        (clk),
		.rst        (rst),
		.issueValid (issueValid),
		.issue      (issue),
		.rsVal      (rsVal),
		.rtVal      (rtVal),
		.memReg     (memReg)
	);

	memStage uMem (
		.clk    (clk),
		.rst    (rst),
		.memReg (memReg),
		.memFwd (memFwd),
		.wbReg  (wbReg)
	);

	writebackStage uWb (
		.wbReg    (wbReg),
		.wbFwd    (wbFwd),
		.regWe    (regWe),
		.regWaddr (regWaddr),
		.regWdata (regWdata),
		.wbValid  (wbValid),
		.wbDst    (wbDst),
		.wbData   (wbData)
	);

endmodule

`default_nettype wire

//--- tb/execPipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defs.svh"

module execPipe_tb;
	import datapathPkg::*;

	localparam int NumInstr = 400;
	localparam int SeedInit = 3954;
	localparam int DriveDelay = 1;
	// one issue plus at most one idle cycle each, with room for reset and drain
	localparam int MaxCycles = NumInstr * 2 + 200;

	typedef enum logic [2:0] {KIND_RR, KIND_RI, KIND_IMM, KIND_LINK, KIND_LOAD, KIND_STORE} kindT;

	// one expected writeback, due at the edge that closes its writeback cycle
	typedef struct packed {
		int      edgeNo;
		int      idx;
		kindT    kind;
		regAddrT dst;
		wordT    value;
	} expT;

	logic    clk;
	logic    rst;
	logic    issueValid;
	instrT   issue;
	logic    wbValid;
	regAddrT wbDst;
	wordT    wbData;

	integer seed;
	int     cycleCount = 0;
	expT    expQ[$];
	wordT   modelRegs [`REG_COUNT];
	wordT   modelMem [`MEM_DEPTH];
	logic   written [8]; // word slots 0 to 7 that a store has filled

	execPipe dut (
		.clk        (clk),
		.rst        (rst),
		.issueValid (issueValid),
		.issue      (issue),
		.wbValid    (wbValid),
		.wbDst      (wbDst),
		.wbData     (wbData)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic string kindName(input kindT kind);
		case (kind)
			KIND_RR:   return "alu_reg_reg";
			KIND_RI:   return "alu_reg_imm";
			KIND_IMM:  return "imm_result";
			KIND_LINK: return "link_result";
			KIND_LOAD: return "load";
			default:   return "store";
		endcase
	endfunction

	// small register set so that back-to-back dependencies are common
	function automatic regAddrT pickReg();
		int n;
		n = $unsigned($random(seed)) % 7;
		return (n == 6) ? regAddrT'(`LINK_REG) : regAddrT'(n);
	endfunction

	task automatic makeInstr(input int idx, output instrT ins, output kindT kind);
		int pick;
		int slot;
		logic [31:0] r;
		pick = $unsigned($random(seed)) % 12;
		slot = $unsigned($random(seed)) % 8;
		r = $random(seed);
		ins = '0;
		ins.rs = pickReg();
		ins.rt = pickReg();
		ins.rd = pickReg();
		ins.imm = r;
		ins.pc = 32'h0000_1000 + 32'(idx * 4);
		ins.aluOp = aluOpT'($unsigned($random(seed)) % 6);
		ins.dstSel = DST_RD;
		ins.resSel = RES_ALU;
		ins.regWrite = 1'b1;
		if (pick < 4) begin
			kind = KIND_RR;
		end else if (pick < 6) begin
			kind = KIND_RI;
			ins.useImm = 1'b1;
			ins.imm = {{16{r[15]}}, r[15:0]}; // sign-extended 16-bit immediate
			ins.dstSel = DST_RT;
		end else if (pick == 6) begin
			kind = KIND_IMM;
			ins.resSel = RES_IMM;
			ins.dstSel = DST_RT;
		end else if (pick == 7) begin
			kind = KIND_LINK;
			ins.resSel = RES_LINK;
			ins.dstSel = DST_LINK;
		end else begin
			ins.rs = '0; // address is r0 plus a word-aligned offset
			ins.useImm = 1'b1;
			ins.aluOp = ALU_ADD;
			ins.imm = 32'(slot * 4);
			ins.dstSel = DST_RT;
			if (pick < 10 && written[slot]) begin
				kind = KIND_LOAD;
				ins.memRead = 1'b1;
			end else begin
				// a load of a never-written word turns into a store
				kind = KIND_STORE;
				ins.memWrite = 1'b1;
				ins.regWrite = 1'b0;
				written[slot] = 1'b1;
			end
		end
	endtask

	// ISA-level execution of one instruction, in program order
	task automatic runModel(input instrT ins, input kindT kind, input int idx,
			input int issueEdge);
		wordT    a;
		wordT    b;
		wordT    aluRes;
		wordT    res;
		regAddrT dst;
		int      slotIdx;
		expT     e;
		a = modelRegs[ins.rs];
		b = ins.useImm ? ins.imm : modelRegs[ins.rt];
		case (ins.aluOp)
			ALU_ADD: aluRes = a + b;
			ALU_SUB: aluRes = a - b;
			ALU_AND: aluRes = a & b;
			ALU_OR:  aluRes = a | b;
			ALU_XOR: aluRes = a ^ b;
			default: aluRes = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
		case (ins.resSel)
			RES_IMM:  res = ins.imm;
			RES_LINK: res = ins.pc + `LINK_OFFSET;
			default:  res = aluRes;
		endcase
		case (ins.dstSel)
			DST_RT:  dst = ins.rt;
			DST_RD:  dst = ins.rd;
			default: dst = regAddrT'(`LINK_REG);
		endcase
		slotIdx = (res >> 2) % `MEM_DEPTH;
		if (ins.memWrite) begin
			modelMem[slotIdx] = modelRegs[ins.rt];
		end
		if (ins.memRead) begin
			res = modelMem[slotIdx];
		end
		if (ins.regWrite) begin
			if (dst != '0) begin
				modelRegs[dst] = res; // r0 reports a writeback but keeps zero
			end
			e.edgeNo = issueEdge + 2;
			e.idx = idx;
			e.kind = kind;
			e.dst = dst;
			e.value = res;
			expQ.push_back(e);
		end
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= MaxCycles) begin
			stopOnError($sformatf("timeout after %0d cycles, %0d writebacks still pending",
				cycleCount, expQ.size()));
		end
	end

	// sampled mid-cycle, away from the edge and from the input drive
	always @(negedge clk) begin : watchWriteback
		expT head;
		if (expQ.size() != 0 && expQ[0].edgeNo == cycleCount + 1) begin
			head = expQ.pop_front();
			assert (wbValid === 1'b1 && wbDst === head.dst && wbData === head.value)
			else stopOnError($sformatf(
				"FAIL %s #%0d: expected dst %0d data %h, actual valid %b dst %0d data %h",
				kindName(head.kind), head.idx, head.dst, head.value, wbValid, wbDst, wbData));
		end else begin
			assert (wbValid === 1'b0)
			else stopOnError($sformatf("writeback seen in cycle %0d where none was due (dst %0d)",
				cycleCount, wbDst));
		end
	end

	initial begin
		instrT ins;
		kindT  kind;
		seed = SeedInit;
		rst = 1'b1;
		issueValid = 1'b0;
		issue = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < `MEM_DEPTH; i++) begin
			modelMem[i] = '0;
		end
		for (int i = 0; i < 8; i++) begin
			written[i] = 1'b0;
		end
		repeat (4) @(posedge clk);
		#DriveDelay;
		rst = 1'b0;
		for (int i = 0; i < NumInstr; i++) begin
			makeInstr(i, ins, kind);
			runModel(ins, kind, i, cycleCount + 1);
			issue = ins;
			issueValid = 1'b1;
			@(posedge clk);
			#DriveDelay;
			issueValid = 1'b0;
			if ($random(seed) % 2 != 0) begin
				@(posedge clk);
				#DriveDelay;
			end
		end
		while (expQ.size() != 0) begin
			@(posedge clk);
		end
		repeat (3) @(negedge clk); // a late extra writeback would be caught here
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+src
src/datapathPkg.sv
src/regFile.sv
src/bypassUnit.sv
src/execStage.sv
src/memStage.sv
src/writebackStage.sv
src/execPipe.sv
tb/execPipe_tb.sv
